// File: hw/sd_settings.svh
// global settings of the SD hub; SD_CLK_DIV must be at least 1
// SD_XFER_CYCLES is derived, so it is never edited by hand

`ifndef SD_SETTINGS_SVH
`define SD_SETTINGS_SVH

//////////////////////////////////////////////////
// spi timing
//////////////////////////////////////////////////

// fclk cycles per sdclk half period
`define SD_CLK_DIV 2

// bits per transfer, msb first
`define SD_BYTE_BITS 8

// start pulse to dataout update, in fclk cycles
`define SD_XFER_CYCLES (2 * `SD_BYTE_BITS * `SD_CLK_DIV + 1)

`endif

// File: hw/sd_pkg.sv
// shared types of the SD hub
// encodings are fixed widths, the lock block and shifter rely on them

package sd_pkg;

	// who may drive the card
	typedef enum logic [1:0]
	{
		OWN_ZX,
		OWN_AVR_WAIT,
		OWN_AVR
	} sd_owner_t;

	// byte shifter phases
	typedef enum logic [1:0]
	{
		SH_IDLE,
		SH_LOW,
		SH_HIGH
	} sd_shift_state_t;

	// side that started the transfer in flight
	typedef enum logic
	{
		SIDE_ZX,
		SIDE_AVR
	} sd_side_t;

endpackage

// File: hw/sd_lock_ctrl.sv
// card ownership, chip select and byte routing for the Z80 and AVR sides
// starts are single-cycle pulses; starts that are not accepted are dropped

`timescale 1ns/1ps

`include "sd_settings.svh"

module sd_lock_ctrl import sd_pkg::*;
(
	input  logic                     fclk,
	input  logic                     reset,

	// Z80 port side
	input  logic                     zx_sdcs_n_val,
	input  logic                     zx_sdcs_n_stb,
	input  logic                     zx_sd_start,
	input  logic [`SD_BYTE_BITS-1:0] zx_sd_datain,
	output logic [`SD_BYTE_BITS-1:0] zx_sd_dataout,

	// AVR side
	input  logic                     avr_lock_claim,
	output logic                     avr_lock_grant,
	input  logic                     avr_sdcs_n,
	input  logic                     avr_sd_start,
	input  logic [`SD_BYTE_BITS-1:0] avr_sd_datain,
	output logic [`SD_BYTE_BITS-1:0] avr_sd_dataout,

	// shifter
	output logic                     xfer_start,
	output logic [`SD_BYTE_BITS-1:0] xfer_txbyte,
	input  logic                     xfer_busy,
	input  logic                     xfer_done,
	input  logic [`SD_BYTE_BITS-1:0] xfer_rxbyte,

	// card chip select
	output logic                     sdcs_n
);

	sd_owner_t owner;
	sd_side_t  xfer_side;
	logic      zx_cs_n;

	logic      zx_owns;
	logic      avr_owns;
	logic      zx_accept;
	logic      avr_accept;

	//////////////////////////////////////////////////
	// start acceptance
	//////////////////////////////////////////////////

	// z80 keeps the card until the grant is actually given
	assign zx_owns  = (owner != OWN_AVR);
	assign avr_owns = (owner == OWN_AVR);

	assign zx_accept  = zx_sd_start  && zx_owns  && !xfer_busy;
	assign avr_accept = avr_sd_start && avr_owns && !xfer_busy;

	assign xfer_start  = zx_accept || avr_accept;
	assign xfer_txbyte = avr_accept ? avr_sd_datain : zx_sd_datain;

	//////////////////////////////////////////////////
	// owner register
	//////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			owner <= OWN_ZX;
		end
		else
		begin
			case (owner)
				OWN_ZX:
				begin
					if (avr_lock_claim)
						owner <= OWN_AVR_WAIT;
				end
				OWN_AVR_WAIT:
				begin
					// a z80 byte starting now delays the grant by one transfer
					if (!avr_lock_claim)
						owner <= OWN_ZX;
					else if (!xfer_busy && !zx_accept)
						owner <= OWN_AVR;
				end
				OWN_AVR:
				begin
					if (!avr_lock_claim && !xfer_busy && !avr_accept)
						owner <= OWN_ZX;
				end
				default:
				begin
					owner <= OWN_ZX;
				end
			endcase
		end
	end

	assign avr_lock_grant = avr_owns;

	//////////////////////////////////////////////////
	// chip select
	//////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
			zx_cs_n <= 1'b1;
		else if (zx_sdcs_n_stb)
			zx_cs_n <= zx_sdcs_n_val;
	end

	assign sdcs_n = avr_owns ? avr_sdcs_n : zx_cs_n;

	//////////////////////////////////////////////////
	// received byte routing
	//////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			xfer_side <= SIDE_ZX;
		end
		else if (xfer_start)
		begin
			xfer_side <= avr_accept ? SIDE_AVR : SIDE_ZX;
		end
	end

	// both dataouts read as idle bus after reset
	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			zx_sd_dataout  <= '1;
			avr_sd_dataout <= '1;
		end
		else if (xfer_done)
		begin
			if (xfer_side == SIDE_AVR)
				avr_sd_dataout <= xfer_rxbyte;
			else
				zx_sd_dataout <= xfer_rxbyte;
		end
	end

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	// grant may only move between transfers
	a_grant_stable: assert property (@(posedge fclk) disable iff (reset)
		$changed(avr_lock_grant) |-> !xfer_busy)
		else $error("avr_lock_grant changed during a transfer");

	// shifter takes every accepted start
	a_start_idle: assert property (@(posedge fclk) disable iff (reset)
		xfer_start |-> !xfer_busy ##1 xfer_busy)
		else $error("xfer_start while busy or not taken by the shifter");

endmodule

// File: hw/sd_shifter.sv
// SPI mode 0 byte shifter, msb first, full duplex
// sdclk half period is SD_CLK_DIV fclk cycles; sddo idles high between bytes

`timescale 1ns/1ps

`include "sd_settings.svh"

module sd_shifter import sd_pkg::*;
(
	input  logic                     fclk,
	input  logic                     reset,

	input  logic                     xfer_start,
	input  logic [`SD_BYTE_BITS-1:0] xfer_txbyte,
	output logic                     xfer_busy,
	output logic                     xfer_done,
	output logic [`SD_BYTE_BITS-1:0] xfer_rxbyte,

	output logic                     sdclk,
	output logic                     sddo,
	input  logic                     sddi
);

	localparam int HALF_W = (`SD_CLK_DIV > 1) ? $clog2(`SD_CLK_DIV) : 1;
	localparam int BIT_W  = (`SD_BYTE_BITS > 1) ? $clog2(`SD_BYTE_BITS) : 1;

	sd_shift_state_t          state;
	logic [HALF_W-1:0]        half_cnt;
	logic [BIT_W-1:0]         bit_cnt;
	logic [`SD_BYTE_BITS-1:0] tx_sh;
	logic [`SD_BYTE_BITS-1:0] rx_sh;

	logic                     half_end;
	logic                     last_bit;

	assign half_end = (half_cnt == HALF_W'(`SD_CLK_DIV - 1));
	assign last_bit = (bit_cnt == BIT_W'(`SD_BYTE_BITS - 1));

	//////////////////////////////////////////////////
	// phase machine
	//////////////////////////////////////////////////

	always_ff @(posedge fclk)
	begin
		if (reset)
		begin
			state    <= SH_IDLE;
			half_cnt <= '0;
			bit_cnt  <= '0;
			sdclk    <= 1'b0;
			tx_sh    <= '1;
		end
		else
		begin
			case (state)
				SH_IDLE:
				begin
					if (xfer_start)
					begin
						// msb goes out right away, first low phase follows
						state    <= SH_LOW;
						half_cnt <= '0;
						bit_cnt  <= '0;
						tx_sh    <= xfer_txbyte;
					end
				end
				SH_LOW:
				begin
					if (half_end)
					begin
						state    <= SH_HIGH;
						half_cnt <= '0;
						sdclk    <= 1'b1;
					end
					else
					begin
						half_cnt <= half_cnt + 1'b1;
					end
				end
				SH_HIGH:
				begin
					if (half_end)
					begin
						half_cnt <= '0;
						sdclk    <= 1'b0;
						// ones fill in behind, so sddo ends high
						tx_sh    <= {tx_sh[`SD_BYTE_BITS-2:0], 1'b1};
						if (last_bit)
						begin
							state <= SH_IDLE;
						end
						else
						begin
							state   <= SH_LOW;
							bit_cnt <= bit_cnt + 1'b1;
						end
					end
					else
					begin
						half_cnt <= half_cnt + 1'b1;
					end
				end
				default:
				begin
					state <= SH_IDLE;
					sdclk <= 1'b0;
				end
			endcase
		end
	end

	// sddi taken on the edge that raises sdclk
	always_ff @(posedge fclk)
	begin
		if (state == SH_LOW && half_end)
			rx_sh <= {rx_sh[`SD_BYTE_BITS-2:0], sddi};
	end

	assign sddo        = tx_sh[`SD_BYTE_BITS-1];
	assign xfer_busy   = (state != SH_IDLE);
	assign xfer_done   = (state == SH_HIGH) && half_end && last_bit;
	assign xfer_rxbyte = rx_sh;

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	a_idle_clk_low: assert property (@(posedge fclk) disable iff (reset)
		(state == SH_IDLE) |-> !sdclk)
		else $error("sdclk high while shifter idle");

	a_done_pulse: assert property (@(posedge fclk) disable iff (reset)
		xfer_done |=> !xfer_done)
		else $error("xfer_done longer than one cycle");

endmodule

// File: hw/sd_hub_top.sv
// SD card hub shared by the Z80 port side and the AVR
// one spi link, one byte in flight, AVR access only after the lock is granted

`timescale 1ns/1ps

module sd_hub_top import sd_pkg::*;
(
	input  logic       fclk,
	input  logic       reset,

	// Z80 port side
	input  logic       zx_sdcs_n_val,
	input  logic       zx_sdcs_n_stb,
	input  logic       zx_sd_start,
	input  logic [7:0] zx_sd_datain,
	output logic [7:0] zx_sd_dataout,

	// AVR side
	input  logic       avr_lock_claim,
	output logic       avr_lock_grant,
	input  logic       avr_sdcs_n,
	input  logic       avr_sd_start,
	input  logic [7:0] avr_sd_datain,
	output logic [7:0] avr_sd_dataout,

	// card
	output logic       sdcs_n,
	output logic       sdclk,
	output logic       sddo,
	input  logic       sddi
);

	// lock block to shifter
	logic       xfer_start;
	logic [7:0] xfer_txbyte;
	logic       xfer_busy;
	logic       xfer_done;
	logic [7:0] xfer_rxbyte;

	sd_lock_ctrl lock0
	(
		.fclk          (fclk          ),
		.reset         (reset         ),
		.zx_sdcs_n_val (zx_sdcs_n_val ),
		.zx_sdcs_n_stb (zx_sdcs_n_stb ),
		.zx_sd_start   (zx_sd_start   ),
		.zx_sd_datain  (zx_sd_datain  ),
		.zx_sd_dataout (zx_sd_dataout ),
		.avr_lock_claim(avr_lock_claim),
		.avr_lock_grant(avr_lock_grant),
		.avr_sdcs_n    (avr_sdcs_n    ),
		.avr_sd_start  (avr_sd_start  ),
		.avr_sd_datain (avr_sd_datain ),
		.avr_sd_dataout(avr_sd_dataout),
		.xfer_start    (xfer_start    ),
		.xfer_txbyte   (xfer_txbyte   ),
		.xfer_busy     (xfer_busy     ),
		.xfer_done     (xfer_done     ),
		.xfer_rxbyte   (xfer_rxbyte   ),
		.sdcs_n        (sdcs_n        )
	);

	sd_shifter shift0
	(
		.fclk       (fclk       ),
		.reset      (reset      ),
		.xfer_start (xfer_start ),
		.xfer_txbyte(xfer_txbyte),
		.xfer_busy  (xfer_busy  ),
		.xfer_done  (xfer_done  ),
		.xfer_rxbyte(xfer_rxbyte),
		.sdclk      (sdclk      ),
		.sddo       (sddo       ),
		.sddi       (sddi       )
	);

endmodule

// File: verif/sd_card_model.sv
// behavioral SD card, SPI mode 0, msb first
// the byte to return is loaded by a pulse on load before the transfer starts

`timescale 1ns/1ps

module sd_card_model
(
	input  logic       sdclk,
	input  logic       sddo,
	input  logic       load,
	input  logic [7:0] load_byte,
	output logic       sddi,
	output logic [7:0] rx_byte
);

	logic [7:0] tx_sh = 8'hFF;
	logic [7:0] rx_sh = 8'hFF;

	// next bit goes out on the falling sdclk edge
	always @(posedge load or negedge sdclk)
	begin
		if (load)
			tx_sh <= load_byte;
		else
			tx_sh <= {tx_sh[6:0], 1'b1};
	end

	// host data is stable around the rising edge
	always @(posedge sdclk)
	begin
		rx_sh <= {rx_sh[6:0], sddo};
	end

	assign sddi    = tx_sh[7];
	assign rx_byte = rx_sh;

endmodule

// File: verif/sd_hub_tb.sv
// testbench of the SD hub; transfers never overlap, so one set of
// expected values serves both sides

`timescale 1ns/1ps

`include "sd_settings.svh"

module sd_hub_tb;

	localparam int XFER = `SD_XFER_CYCLES;

	logic       fclk = 1'b0;
	logic       reset = 1'b1;
	logic       zx_sdcs_n_val = 1'b1;
	logic       zx_sdcs_n_stb = 1'b0;
	logic       zx_sd_start = 1'b0;
	logic [7:0] zx_sd_datain = 8'h00;
	logic       avr_lock_claim = 1'b0;
	logic       avr_sdcs_n = 1'b1;
	logic       avr_sd_start = 1'b0;
	logic [7:0] avr_sd_datain = 8'h00;
	logic       sddi;
	logic [7:0] zx_sd_dataout;
	logic [7:0] avr_sd_dataout;
	logic       avr_lock_grant;
	logic       sdcs_n;
	logic       sdclk;
	logic       sddo;

	logic       card_load = 1'b0;
	logic [7:0] card_byte = 8'hFF;
	logic [7:0] card_rx;

	// expected values of the transfer in flight
	int         errors = 0;
	logic [31:0] lfsr = 32'd90368;
	int         xfer_age = -1;
	int         blk_age = -1;
	int         claim_age = -1;
	int         rel_age = -1;
	logic       chk_reset = 1'b0;
	logic       xfer_avr = 1'b0;
	logic [7:0] exp_tx = 8'h00;
	logic [7:0] own_prev = 8'hFF;
	logic [7:0] other_keep = 8'hFF;
	logic       cs_model;
	logic [7:0] own_out;
	logic [7:0] other_out;

	sd_hub_top dut0
	(
		.fclk          (fclk          ),
		.reset         (reset         ),
		.zx_sdcs_n_val (zx_sdcs_n_val ),
		.zx_sdcs_n_stb (zx_sdcs_n_stb ),
		.zx_sd_start   (zx_sd_start   ),
		.zx_sd_datain  (zx_sd_datain  ),
		.zx_sd_dataout (zx_sd_dataout ),
		.avr_lock_claim(avr_lock_claim),
		.avr_lock_grant(avr_lock_grant),
		.avr_sdcs_n    (avr_sdcs_n    ),
		.avr_sd_start  (avr_sd_start  ),
		.avr_sd_datain (avr_sd_datain ),
		.avr_sd_dataout(avr_sd_dataout),
		.sdcs_n        (sdcs_n        ),
		.sdclk         (sdclk         ),
		.sddo          (sddo          ),
		.sddi          (sddi          )
	);

	sd_card_model card0
	(
		.sdclk    (sdclk    ),
		.sddo     (sddo     ),
		.load     (card_load),
		.load_byte(card_byte),
		.sddi     (sddi     ),
		.rx_byte  (card_rx  )
	);

	initial
	begin
		forever
			#20 fclk = ~fclk;
	end

	assign own_out   = xfer_avr ? avr_sd_dataout : zx_sd_dataout;
	assign other_out = xfer_avr ? zx_sd_dataout : avr_sd_dataout;

	//////////////////////////////////////////////////
	// reference state and age counters
	//////////////////////////////////////////////////

	// chip-select register loads one cycle after the strobe
	always @(posedge fclk)
	begin
		if (reset)
			cs_model <= 1'b1;
		else if (zx_sdcs_n_stb)
			cs_model <= zx_sdcs_n_val;
		if (xfer_age >= 0 && xfer_age < XFER + 4)
			xfer_age <= xfer_age + 1;
		if (blk_age >= 0 && blk_age < XFER + 4)
			blk_age <= blk_age + 1;
		if (claim_age >= 0 && claim_age < XFER + 4)
			claim_age <= claim_age + 1;
		if (rel_age >= 0 && rel_age < 4)
			rel_age <= rel_age + 1;
	end

	//////////////////////////////////////////////////
	// error reporting
	//////////////////////////////////////////////////

	task automatic report_mismatch(input string name, input logic [31:0] exp_v,
		input logic [31:0] got_v);
		errors = errors + 1;
		$display("FAILED %0t %s expected %0h got %0h", $time, name, exp_v, got_v);
	endtask

	function automatic string dataout_name(input logic avr);
		if (avr)
			return "avr_sd_dataout";
		return "zx_sd_dataout";
	endfunction

	//////////////////////////////////////////////////
	// checks
	//////////////////////////////////////////////////

	a_reset: assert property (@(posedge fclk) chk_reset |->
		{sdcs_n, sdclk, sddo, avr_lock_grant, zx_sd_dataout, avr_sd_dataout} == 20'hA_FFFF)
		else report_mismatch("{sdcs_n,sdclk,sddo,avr_lock_grant,zx/avr_sd_dataout}",
			32'hA_FFFF, {sdcs_n, sdclk, sddo, avr_lock_grant, zx_sd_dataout, avr_sd_dataout});

	a_zx_cs: assert property (@(posedge fclk) (!reset && !avr_lock_grant) |-> sdcs_n == cs_model)
		else report_mismatch("sdcs_n", cs_model, sdcs_n);

	a_avr_cs: assert property (@(posedge fclk) avr_lock_grant |-> sdcs_n == avr_sdcs_n)
		else report_mismatch("sdcs_n", avr_sdcs_n, sdcs_n);

	// the byte must not land one cycle early
	a_hold: assert property (@(posedge fclk) (xfer_age == XFER - 1) |-> own_out == own_prev)
		else report_mismatch(dataout_name(xfer_avr), own_prev, own_out);

	a_rx: assert property (@(posedge fclk) (xfer_age == XFER) |-> own_out == card_byte)
		else report_mismatch(dataout_name(xfer_avr), card_byte, own_out);

	a_card: assert property (@(posedge fclk) (xfer_age == XFER) |-> card_rx == exp_tx)
		else report_mismatch("card_rx", exp_tx, card_rx);

	a_other: assert property (@(posedge fclk) (xfer_age == XFER) |-> other_out == other_keep)
		else report_mismatch(dataout_name(!xfer_avr), other_keep, other_out);

	a_blocked: assert property (@(posedge fclk) (blk_age >= 0 && blk_age <= XFER) |-> !sdclk)
		else report_mismatch("sdclk", 0, sdclk);

	a_grant: assert property (@(posedge fclk) (claim_age == XFER + 2) |-> avr_lock_grant)
		else report_mismatch("avr_lock_grant", 1, avr_lock_grant);

	a_release: assert property (@(posedge fclk) (rel_age == 2) |-> !avr_lock_grant)
		else report_mismatch("avr_lock_grant", 0, avr_lock_grant);

	//////////////////////////////////////////////////
	// stimulus helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hB4BCD35C) : (s >> 1);
	endfunction

	task automatic rand_byte(output logic [7:0] b);
		b = 8'h00;
		for (int i = 0; i < 8; i++)
		begin
			b = {b[6:0], lfsr[0]};
			lfsr = lfsr_next(lfsr);
		end
	endtask

	// loads the card, then issues one start that the hub is expected to accept
	task automatic start_xfer(input logic avr);
		logic [7:0] tx;
		logic [7:0] cb;
		rand_byte(tx);
		rand_byte(cb);
		card_byte <= cb;
		card_load <= 1'b1;
		@(posedge fclk);
		card_load  <= 1'b0;
		xfer_avr   <= avr;
		exp_tx     <= tx;
		own_prev   <= avr ? avr_sd_dataout : zx_sd_dataout;
		other_keep <= avr ? zx_sd_dataout : avr_sd_dataout;
		xfer_age   <= 0;
		if (avr)
		begin
			avr_sd_datain <= tx;
			avr_sd_start  <= 1'b1;
		end
		else
		begin
			zx_sd_datain <= tx;
			zx_sd_start  <= 1'b1;
		end
		@(posedge fclk);
		avr_sd_start <= 1'b0;
		zx_sd_start  <= 1'b0;
	endtask

	task automatic wait_xfer();
		int n;
		n = 0;
		while (xfer_age <= XFER && n < XFER + 8)
		begin
			@(posedge fclk);
			n++;
		end
		if (xfer_age <= XFER)
		begin
			errors = errors + 1;
			$display("transfer check never reached before the timeout");
		end
		@(posedge fclk);
	endtask

	task automatic wait_grant(input logic level, input int limit);
		int n;
		n = 0;
		while (avr_lock_grant !== level && n < limit)
		begin
			@(posedge fclk);
			n++;
		end
		if (avr_lock_grant !== level)
		begin
			errors = errors + 1;
			$display("avr_lock_grant did not reach %b before the timeout", level);
		end
	endtask

	//////////////////////////////////////////////////
	// sequence
	//////////////////////////////////////////////////

	initial
	begin
		int n;
		repeat (8) @(posedge fclk);
		reset <= 1'b0;
		@(posedge fclk);
		chk_reset <= 1'b1;
		@(posedge fclk);
		chk_reset     <= 1'b0;
		zx_sdcs_n_val <= 1'b0;
		zx_sdcs_n_stb <= 1'b1;
		@(posedge fclk);
		zx_sdcs_n_stb <= 1'b0;
		start_xfer(1'b0);
		wait_xfer();

		// claim while a z80 byte is still on the wire
		start_xfer(1'b0);
		repeat (3) @(posedge fclk);
		avr_lock_claim <= 1'b1;
		claim_age      <= 0;
		avr_sdcs_n     <= 1'b0;
		wait_grant(1'b1, XFER + 4);
		wait_xfer();

		// avr deselects the card while the z80 start is refused
		blk_age     <= 0;
		avr_sdcs_n  <= 1'b1;
		zx_sd_start <= 1'b1;
		@(posedge fclk);
		zx_sd_start <= 1'b0;
		n = 0;
		while (blk_age <= XFER && n < XFER + 8)
		begin
			@(posedge fclk);
			n++;
		end
		if (blk_age <= XFER)
		begin
			errors = errors + 1;
			$display("blocked start check never reached before the timeout");
		end

		avr_sdcs_n <= 1'b0;
		start_xfer(1'b1);
		wait_xfer();
		avr_sdcs_n     <= 1'b1;
		avr_lock_claim <= 1'b0;
		rel_age        <= 0;
		wait_grant(1'b0, 4);
		repeat (3) @(posedge fclk);
		start_xfer(1'b0);
		wait_xfer();

		$display("errors: %0d", errors);
		if (errors == 0)
			$display("STATUS: PASS");
		else
			$display("STATUS: FAIL");
		$finish;
	end

	// last line of defense against a stuck sequence
	initial
	begin
		#2ms;
		$display("simulation ran past its time limit");
		$display("STATUS: FAIL");
		$finish;
	end

endmodule

// File: tb.f
+incdir+hw
hw/sd_pkg.sv
hw/sd_lock_ctrl.sv
hw/sd_shifter.sv
hw/sd_hub_top.sv
verif/sd_card_model.sv
verif/sd_hub_tb.sv

// File: run.sh
#!/usr/bin/env bash
# builds the SD hub testbench with Verilator and runs it

set -u
cd "$(dirname "$0")"

verilator --binary --timing --assert -f tb.f \
	--top-module sd_hub_tb --Mdir obj_dir -o sd_hub_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/sd_hub_sim > sim.log 2>&1
rc=$?
cat sim.log
if [ $rc -ne 0 ]; then
	echo "simulation exited with status $rc"
	exit 1
fi

if grep -q "^STATUS: PASS$" sim.log; then
	exit 0
fi
echo "pass message not found in sim.log"
exit 1
